// ==== design/icache_pkg.sv ====
// Instruction cache shared definitions
package icache_pkg;

   // Physical fetch address and word widths
   localparam int addr_w = 16;
   localparam int word_w = 32;

   // Default geometry of 8 sets of 4 ways with 16-byte lines
   localparam int def_sets_log2 = 3;
   localparam int def_ways_log2 = 2;
   localparam int def_line_log2 = 4;

   // Bytes per cache word
   localparam int word_bytes_log2 = 2;

   // Refill controller states
   typedef enum logic [1:0] {
      st_idle    = 2'b00,
      st_pending = 2'b01,
      st_readout = 2'b10,
      st_boot    = 2'b11
   } icache_state_t;

endpackage

// ==== design/icache_tag_store.sv ====
// Cache tag and LRU age arrays
`timescale 1ns/1ps

module icache_tag_store #(
   parameter int sets_log2 = icache_pkg::def_sets_log2,
   parameter int ways_log2 = icache_pkg::def_ways_log2,
   parameter int line_log2 = icache_pkg::def_line_log2,
   localparam int ways = 1 << ways_log2,
   localparam int tag_w = icache_pkg::addr_w - sets_log2 - line_log2
) (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            rd_en,
   input  logic [sets_log2-1:0]            rd_idx,
   input  logic [sets_log2-1:0]            wr_idx,
   input  logic [ways-1:0]                 tag_we,
   input  logic [ways-1:0]                 tag_v_in,
   input  logic [ways-1:0][tag_w-1:0]      tag_in,
   input  logic                            age_we,
   input  logic [ways-1:0][ways_log2-1:0]  age_in,
   output logic [ways-1:0]                 tag_v,
   output logic [ways-1:0][tag_w-1:0]      tag,
   output logic [ways-1:0][ways_log2-1:0]  age
);

   for (genvar w = 0; w < ways; w++)
   begin : g_way
      logic [tag_w:0]          vt_mem [1 << sets_log2];
      logic [ways_log2-1:0]    age_mem [1 << sets_log2];
      logic                    v_q;
      logic [tag_w-1:0]        tag_q;
      logic [ways_log2-1:0]    age_q;
      logic                    tag_fwd;
      logic                    age_fwd;

      always_ff @(posedge clk)
      begin
         if (tag_we[w])
            vt_mem[wr_idx] <= {tag_v_in[w], tag_in[w]};
         if (age_we)
            age_mem[wr_idx] <= age_in[w];
      end

      // Back-to-back hits to one set must see the ages just written
      assign tag_fwd = tag_we[w] & (wr_idx == rd_idx);
      assign age_fwd = age_we & (wr_idx == rd_idx);

      always_ff @(posedge clk or negedge rst_n)
      begin
         if (!rst_n)
            v_q <= 1'b0;
         else if (rd_en)
            v_q <= tag_fwd ? tag_v_in[w] : vt_mem[rd_idx][tag_w];
      end

      always_ff @(posedge clk)
      begin
         if (rd_en)
         begin
            tag_q <= tag_fwd ? tag_in[w] : vt_mem[rd_idx][tag_w-1:0];
            age_q <= age_fwd ? age_in[w] : age_mem[rd_idx];
         end
      end

      assign tag_v[w] = v_q;
      assign tag[w]   = tag_q;
      assign age[w]   = age_q;
   end

endmodule

// ==== design/icache_lookup.sv ====
// Tag compare and LRU maintenance
`timescale 1ns/1ps

module icache_lookup #(
   parameter int sets_log2 = icache_pkg::def_sets_log2,
   parameter int ways_log2 = icache_pkg::def_ways_log2,
   parameter int line_log2 = icache_pkg::def_line_log2,
   localparam int ways = 1 << ways_log2,
   localparam int tag_w = icache_pkg::addr_w - sets_log2 - line_log2
) (
   input  icache_pkg::icache_state_t       state,
   input  logic [sets_log2-1:0]            boot_idx,
   input  logic                            req_vld,
   input  logic [icache_pkg::addr_w-1:0]   req_addr,
   input  logic [ways-1:0]                 tag_v,
   input  logic [ways-1:0][tag_w-1:0]      tag,
   input  logic [ways-1:0][ways_log2-1:0]  age,
   output logic                            hit,
   output logic [ways_log2-1:0]            match_way,
   output logic [ways_log2-1:0]            victim_way,
   output logic [ways-1:0]                 tag_we,
   output logic [ways-1:0]                 tag_v_in,
   output logic [ways-1:0][tag_w-1:0]      tag_in,
   output logic                            age_we,
   output logic [ways-1:0][ways_log2-1:0]  age_in
);
   import icache_pkg::*;

   logic [tag_w-1:0]       req_tag;
   logic [ways-1:0]        match;
   logic [ways-1:0]        zero_age;
   logic [ways_log2-1:0]   hit_age;

   assign req_tag = req_addr[addr_w-1 -: tag_w];

   for (genvar w = 0; w < ways; w++)
   begin : g_cmp
      assign match[w]    = req_vld & tag_v[w] & (tag[w] == req_tag);
      assign zero_age[w] = (age[w] == '0);
   end

   assign hit = |match;

   // OR encoders for one-hot inputs
   always_comb
   begin
      match_way  = '0;
      victim_way = '0;
      hit_age    = '0;
      for (int w = 0; w < ways; w++)
      begin
         if (match[w])
         begin
            match_way = match_way | ways_log2'(w);
            hit_age   = hit_age | age[w];
         end
         if (zero_age[w])
            victim_way = victim_way | ways_log2'(w);
      end
   end

   always_comb
   begin
      tag_we   = '0;
      tag_v_in = '0;
      tag_in   = '0;
      age_we   = 1'b0;
      age_in   = age;
      if (state == st_boot)
      begin
         // Invalidate all ways and seed distinct ages
         tag_we = '1;
         age_we = 1'b1;
         for (int w = 0; w < ways; w++)
            age_in[w] = ways_log2'(w);
      end
      else if (state == st_idle && req_vld)
      begin
         if (hit)
         begin
            // Matched way becomes youngest and younger ones shift down
            age_we = 1'b1;
            for (int w = 0; w < ways; w++)
               age_in[w] = match[w] ? '1 : age[w] - ways_log2'(age[w] > hit_age);
         end
         else
         begin
            tag_we[victim_way] = 1'b1;
            tag_v_in = '1;
            for (int w = 0; w < ways; w++)
               tag_in[w] = req_tag;
         end
      end
   end

   always_comb
   begin
      if (req_vld)
      begin
         assert final ($onehot0(match))
            else $error("tag match on more than one way");
         assert final ($onehot(zero_age))
            else $error("LRU ages of the set are not a permutation");
      end
      // Stall keeps the fetch side out until every set is cleared
      if (state == st_boot)
         assert final (!req_vld)
            else $error("request accepted during boot at set %0d", boot_idx);
   end

endmodule

// ==== design/icache_data_store.sv ====
// Cache line data arrays
`timescale 1ns/1ps

module icache_data_store #(
   parameter int sets_log2 = icache_pkg::def_sets_log2,
   parameter int ways_log2 = icache_pkg::def_ways_log2,
   parameter int line_log2 = icache_pkg::def_line_log2,
   localparam int ways = 1 << ways_log2,
   localparam int word_aw = sets_log2 + line_log2 - icache_pkg::word_bytes_log2
) (
   input  logic                            clk,
   input  logic                            rd_en,
   input  logic [word_aw-1:0]              rd_word_addr,
   input  logic                            refill_we,
   input  logic [ways_log2-1:0]            refill_way,
   input  logic [word_aw-1:0]              refill_word_addr,
   input  logic [icache_pkg::word_w-1:0]   r_data,
   input  logic [ways_log2-1:0]            match_way,
   output logic [icache_pkg::word_w-1:0]   dout
);
   import icache_pkg::*;

   logic [word_w-1:0] way_dout [ways];

   for (genvar w = 0; w < ways; w++)
   begin : g_way
      logic [word_w-1:0]  mem [1 << word_aw];
      logic [word_w-1:0]  rd_q;
      logic               wr_sel;

      // Beats land only in the way chosen for replacement
      assign wr_sel = refill_we & (refill_way == ways_log2'(w));

      always_ff @(posedge clk)
      begin
         if (wr_sel)
            mem[refill_word_addr] <= r_data;
      end

      always_ff @(posedge clk)
      begin
         if (rd_en)
            rd_q <= mem[rd_word_addr];
      end

      assign way_dout[w] = rd_q;
   end

   // All ways are read in parallel, the hit picks one
   assign dout = way_dout[match_way];

endmodule

// ==== design/icache_refill_ctrl.sv ====
// Cache boot and refill controller
`timescale 1ns/1ps

module icache_refill_ctrl #(
   parameter int sets_log2 = icache_pkg::def_sets_log2,
   parameter int line_log2 = icache_pkg::def_line_log2,
   localparam int off_w = line_log2 - icache_pkg::word_bytes_log2
) (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            req_vld,
   input  logic                            hit,
   input  logic [icache_pkg::addr_w-1:0]   req_addr,
   input  logic                            ar_ready,
   input  logic                            r_valid,
   output icache_pkg::icache_state_t       state,
   output logic [sets_log2-1:0]            boot_idx,
   output logic [off_w-1:0]                beat_cnt,
   output logic                            refill_we,
   output logic                            tag_reread,
   output logic                            stall,
   output logic                            dout_vld,
   output logic                            ar_valid,
   output logic [icache_pkg::addr_w-1:0]   ar_addr
);
   import icache_pkg::*;

   icache_state_t  state_nxt;
   logic           miss;
   logic           last_beat;

   assign miss      = (state == st_idle) & req_vld & ~hit;
   assign refill_we = r_valid & (state == st_pending);
   assign last_beat = refill_we & (&beat_cnt);

   always_comb
   begin
      state_nxt = state;
      case (state)
         st_boot:
            if (boot_idx == '0)
               state_nxt = st_readout;
         st_idle:
            if (miss)
               state_nxt = st_pending;
         st_pending:
            if (last_beat)
               state_nxt = st_readout;
         st_readout:
            state_nxt = st_idle;
         default:
            state_nxt = st_boot;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state    <= st_boot;
         boot_idx <= '1;
         beat_cnt <= '0;
         ar_valid <= 1'b0;
      end
      else
      begin
         state <= state_nxt;
         // Sweep from the top set down to zero
         if (state == st_boot)
            boot_idx <= boot_idx - 1'b1;
         // Wraps back to zero after the last word of the line
         if (refill_we)
            beat_cnt <= beat_cnt + 1'b1;
         if (miss)
            ar_valid <= 1'b1;
         else if (ar_valid && ar_ready)
            ar_valid <= 1'b0;
      end
   end

   // Tags and data are stale after a refill or the boot sweep
   assign tag_reread = (state == st_readout);

   assign stall    = (state != st_idle) | (req_vld & ~hit);
   assign dout_vld = (state == st_idle) & hit;

   // Request is held in stage 1 for the whole miss
   assign ar_addr = {req_addr[addr_w-1:line_log2], {line_log2{1'b0}}};

   a_ar_hold: assert property (
      @(posedge clk) disable iff (!rst_n)
      ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr)
   ) else $error("ar_valid or ar_addr changed before the handshake");

   a_r_in_pending: assert property (
      @(posedge clk) disable iff (!rst_n)
      r_valid |-> state == st_pending
   ) else $error("read beat outside a pending refill");

endmodule

// ==== design/icache_top.sv ====
// Set-associative instruction cache
`timescale 1ns/1ps

module icache_top #(
   parameter int sets_log2 = icache_pkg::def_sets_log2,
   parameter int ways_log2 = icache_pkg::def_ways_log2,
   parameter int line_log2 = icache_pkg::def_line_log2,
   localparam int ways = 1 << ways_log2,
   localparam int tag_w = icache_pkg::addr_w - sets_log2 - line_log2,
   localparam int off_w = line_log2 - icache_pkg::word_bytes_log2
) (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            re,
   input  logic [icache_pkg::addr_w-1:0]   addr,
   output logic [icache_pkg::word_w-1:0]   dout,
   output logic                            dout_vld,
   output logic                            stall,
   input  logic                            ar_ready,
   output logic                            ar_valid,
   output logic [icache_pkg::addr_w-1:0]   ar_addr,
   input  logic                            r_valid,
   input  logic [icache_pkg::word_w-1:0]   r_data
);
   import icache_pkg::*;

   icache_state_t                    state;
   logic [sets_log2-1:0]             boot_idx;
   logic [off_w-1:0]                 beat_cnt;
   logic                             refill_we;
   logic                             tag_reread;

   logic                             accept;
   logic                             req_vld;
   logic [addr_w-1:0]                req_addr;
   logic [sets_log2-1:0]             req_idx;
   logic                             rd_en;
   logic [sets_log2-1:0]             rd_idx;
   logic [sets_log2-1:0]             wr_idx;
   logic [sets_log2+off_w-1:0]       rd_word_addr;
   logic [sets_log2+off_w-1:0]       refill_word_addr;

   logic [ways-1:0]                  tag_v;
   logic [ways-1:0][tag_w-1:0]       tag;
   logic [ways-1:0][ways_log2-1:0]   age;
   logic                             hit;
   logic [ways_log2-1:0]             match_way;
   logic [ways_log2-1:0]             victim_way;
   logic [ways-1:0]                  tag_we;
   logic [ways-1:0]                  tag_v_in;
   logic [ways-1:0][tag_w-1:0]       tag_in;
   logic                             age_we;
   logic [ways-1:0][ways_log2-1:0]   age_in;

   assign accept = re & ~stall;

   // Stage 1 holds the accepted request until the lookup resolves
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         req_vld <= 1'b0;
      else if (!stall)
         req_vld <= re;
   end

   always_ff @(posedge clk)
   begin
      if (accept)
         req_addr <= addr;
   end

   assign req_idx = req_addr[line_log2 +: sets_log2];

   // Keep indexing the held request while stalled, so readout rereads it
   assign rd_en  = accept | tag_reread;
   assign rd_idx = stall ? req_idx : addr[line_log2 +: sets_log2];
   assign wr_idx = (state == st_boot) ? boot_idx : req_idx;

   assign rd_word_addr = stall ? {req_idx, req_addr[word_bytes_log2 +: off_w]}
                               : {addr[line_log2 +: sets_log2], addr[word_bytes_log2 +: off_w]};
   assign refill_word_addr = {req_idx, beat_cnt};

   icache_tag_store #(
      .sets_log2 (sets_log2),
      .ways_log2 (ways_log2),
      .line_log2 (line_log2)
   ) tag_store_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .rd_en    (rd_en),
      .rd_idx   (rd_idx),
      .wr_idx   (wr_idx),
      .tag_we   (tag_we),
      .tag_v_in (tag_v_in),
      .tag_in   (tag_in),
      .age_we   (age_we),
      .age_in   (age_in),
      .tag_v    (tag_v),
      .tag      (tag),
      .age      (age)
   );

   icache_lookup #(
      .sets_log2 (sets_log2),
      .ways_log2 (ways_log2),
      .line_log2 (line_log2)
   ) lookup_i (
      .state      (state),
      .boot_idx   (boot_idx),
      .req_vld    (req_vld),
      .req_addr   (req_addr),
      .tag_v      (tag_v),
      .tag        (tag),
      .age        (age),
      .hit        (hit),
      .match_way  (match_way),
      .victim_way (victim_way),
      .tag_we     (tag_we),
      .tag_v_in   (tag_v_in),
      .tag_in     (tag_in),
      .age_we     (age_we),
      .age_in     (age_in)
   );

   icache_data_store #(
      .sets_log2 (sets_log2),
      .ways_log2 (ways_log2),
      .line_log2 (line_log2)
   ) data_store_i (
      .clk              (clk),
      .rd_en            (rd_en),
      .rd_word_addr     (rd_word_addr),
      .refill_we        (refill_we),
      .refill_way       (victim_way),
      .refill_word_addr (refill_word_addr),
      .r_data           (r_data),
      .match_way        (match_way),
      .dout             (dout)
   );

   icache_refill_ctrl #(
      .sets_log2 (sets_log2),
      .line_log2 (line_log2)
   ) refill_ctrl_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .req_vld    (req_vld),
      .hit        (hit),
      .req_addr   (req_addr),
      .ar_ready   (ar_ready),
      .r_valid    (r_valid),
      .state      (state),
      .boot_idx   (boot_idx),
      .beat_cnt   (beat_cnt),
      .refill_we  (refill_we),
      .tag_reread (tag_reread),
      .stall      (stall),
      .dout_vld   (dout_vld),
      .ar_valid   (ar_valid),
      .ar_addr    (ar_addr)
   );

endmodule

// ==== tb/icache_checker.sv ====
// Instruction cache response checker
`timescale 1ns/1ps

module icache_checker #(
   parameter int sets_log2 = icache_pkg::def_sets_log2,
   parameter int ways_log2 = icache_pkg::def_ways_log2,
   parameter int line_log2 = icache_pkg::def_line_log2
) (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            re,
   input  logic [icache_pkg::addr_w-1:0]   addr,
   input  logic [127:0]                    test_name,
   input  logic                            test_refill,
   input  logic                            stall,
   input  logic [icache_pkg::word_w-1:0]   dout,
   input  logic                            dout_vld,
   input  logic                            ar_valid,
   input  logic                            ar_ready,
   input  logic [icache_pkg::addr_w-1:0]   ar_addr,
   input  logic                            r_valid,
   output int                              data_errs,
   output int                              refill_errs,
   output int                              proto_errs,
   output int                              outstanding
);
   import icache_pkg::*;

   localparam int sets = 1 << sets_log2;
   localparam int ways = 1 << ways_log2;
   localparam int words = 1 << (line_log2 - word_bytes_log2);
   localparam int boot_cycles = sets + 1;

   // Requests in flight with the oldest first
   logic [addr_w-1:0]   q_addr [$];
   logic [127:0]        q_name [$];
   logic                q_model_refill [$];
   logic                q_table_refill [$];
   int                  q_cyc [$];

   // Reference copy of the tags and LRU ages
   logic                m_valid [sets][ways];
   int                  m_tag [sets][ways];
   int                  m_age [sets][ways];

   int                  boot_cnt;
   int                  hs_cnt;
   int                  beat_cnt;
   int                  cyc;
   int                  beat_cyc;
   logic                ar_waiting;
   logic [addr_w-1:0]   ar_addr_q;

   // Scrambled word by the same rule as the bus slave memory
   function automatic logic [word_w-1:0] model_word(input logic [addr_w-1:0] byte_addr);
      logic [31:0] a;
      a = 32'(byte_addr >> word_bytes_log2);
      return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]};
   endfunction

   task automatic model_access(input logic [addr_w-1:0] a, output logic refill);
      int s;
      int t;
      int hw;
      int old;
      s = int'(a[line_log2 +: sets_log2]);
      t = int'(a >> (line_log2 + sets_log2));
      hw = -1;
      for (int w = 0; w < ways; w++)
         if (m_valid[s][w] && m_tag[s][w] == t)
            hw = w;
      refill = (hw < 0);
      if (refill)
      begin
         // Way with age zero is the least recently used
         for (int w = 0; w < ways; w++)
            if (m_age[s][w] == 0)
               hw = w;
         m_valid[s][hw] = 1'b1;
         m_tag[s][hw] = t;
      end
      old = m_age[s][hw];
      for (int w = 0; w < ways; w++)
      begin
         if (w == hw)
            m_age[s][w] = ways - 1;
         else if (m_age[s][w] > old)
            m_age[s][w] = m_age[s][w] - 1;
      end
   endtask

   task automatic finish_request();
      logic [addr_w-1:0]   a;
      logic [127:0]        name;
      logic                model_refill;
      logic                table_refill;
      logic                act_refill;
      int                  acc_cyc;
      a = q_addr.pop_front();
      name = q_name.pop_front();
      model_refill = q_model_refill.pop_front();
      table_refill = q_table_refill.pop_front();
      acc_cyc = q_cyc.pop_front();
      act_refill = (hs_cnt != 0);
      if (dout !== model_word(a))
      begin
         data_errs++;
         $display("ERROR %0s: dout expected %h actual %h", name, model_word(a), dout);
      end
      if (act_refill != model_refill)
      begin
         refill_errs++;
         $display("ERROR %0s: LRU refill expected %0d actual %0d", name, model_refill,
                  act_refill);
      end
      if (act_refill != table_refill)
      begin
         refill_errs++;
         $display("ERROR %0s: refill expected %0d actual %0d", name, table_refill, act_refill);
      end
      if (hs_cnt > 1 || beat_cnt != hs_cnt * words)
      begin
         proto_errs++;
         $display("%0s saw %0d address handshakes and %0d data beats for one request",
                  name, hs_cnt, beat_cnt);
      end
      // A hit answers in the next cycle, a refill after one readout cycle
      if (!act_refill && cyc - acc_cyc != 1)
      begin
         proto_errs++;
         $display("ERROR %0s: hit latency expected 1 actual %0d", name, cyc - acc_cyc);
      end
      if (act_refill && cyc - beat_cyc != 2)
      begin
         proto_errs++;
         $display("ERROR %0s: cycles from last beat to data expected 2 actual %0d", name,
                  cyc - beat_cyc);
      end
      hs_cnt = 0;
      beat_cnt = 0;
   endtask

   always @(posedge clk or negedge rst_n)
   begin
      logic refill;
      if (!rst_n)
      begin
         for (int s = 0; s < sets; s++)
            for (int w = 0; w < ways; w++)
            begin
               m_valid[s][w] = 1'b0;
               m_tag[s][w] = 0;
               m_age[s][w] = w;
            end
         q_addr.delete();
         q_name.delete();
         q_model_refill.delete();
         q_table_refill.delete();
         q_cyc.delete();
         boot_cnt = 0;
         hs_cnt = 0;
         beat_cnt = 0;
         cyc = 0;
         beat_cyc = 0;
         ar_waiting = 1'b0;
         outstanding = 0;
      end
      else
      begin
         cyc++;
         if (boot_cnt < boot_cycles)
         begin
            boot_cnt++;
            if (!stall || ar_valid)
            begin
               proto_errs++;
               $display("Boot cycle %0d let the fetch side in or requested a line", boot_cnt);
            end
         end
         if (ar_waiting && (!ar_valid || ar_addr != ar_addr_q))
         begin
            proto_errs++;
            $display("Line request dropped or its address changed before ar_ready");
         end
         ar_waiting = ar_valid && !ar_ready;
         ar_addr_q = ar_addr;
         if (ar_valid && ar_ready)
         begin
            if (q_addr.size() == 0)
            begin
               proto_errs++;
               $display("Line request with no fetch in flight");
            end
            else
            begin
               hs_cnt++;
               if (ar_addr != (q_addr[0] & ~addr_w'((1 << line_log2) - 1)))
               begin
                  proto_errs++;
                  $display("ERROR %0s: ar_addr expected %h actual %h", q_name[0],
                           q_addr[0] & ~addr_w'((1 << line_log2) - 1), ar_addr);
               end
            end
         end
         if (r_valid)
         begin
            beat_cnt++;
            beat_cyc = cyc;
         end
         if (dout_vld)
         begin
            if (q_addr.size() == 0)
            begin
               proto_errs++;
               $display("Data valid with no fetch in flight");
            end
            else
               finish_request();
         end
         if (re && !stall)
         begin
            model_access(addr, refill);
            q_addr.push_back(addr);
            q_name.push_back(test_name);
            q_model_refill.push_back(refill);
            q_table_refill.push_back(test_refill);
            q_cyc.push_back(cyc);
         end
         outstanding = q_addr.size();
      end
   end

endmodule

// ==== tb/icache_tb.sv ====
// Instruction cache testbench
`timescale 1ns/1ps

module icache_tb;
   import icache_pkg::*;

   localparam int sets_log2 = def_sets_log2;
   localparam int ways_log2 = def_ways_log2;
   localparam int line_log2 = def_line_log2;
   localparam int words = 1 << (line_log2 - word_bytes_log2);
   localparam int boot_cycles = (1 << sets_log2) + 1;
   localparam int clk_period = 100;
   localparam int max_delay = 3;
   // Longest address wait plus every beat after its longest gap
   localparam int refill_bound = max_delay + 1 + words * (max_delay + 1) + 4;

   typedef struct packed {
      logic [127:0]        name;
      logic [addr_w-1:0]   addr;
      logic                refill;
   } row_t;

   logic                clk = 1'b0;
   logic                rst_n;
   logic                re;
   logic [addr_w-1:0]   addr;
   logic [word_w-1:0]   dout;
   logic                dout_vld;
   logic                stall;
   logic                ar_ready;
   logic                ar_valid;
   logic [addr_w-1:0]   ar_addr;
   logic                r_valid;
   logic [word_w-1:0]   r_data;
   logic [127:0]        cur_name;
   logic                cur_refill;
   int                  data_errs;
   int                  refill_errs;
   int                  proto_errs;
   int                  outstanding;
   row_t                rows [$];
   logic [31:0]         lfsr;

   always #(clk_period / 2) clk = ~clk;

   icache_top #(
      .sets_log2 (sets_log2),
      .ways_log2 (ways_log2),
      .line_log2 (line_log2)
   ) icache_top_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .re       (re),
      .addr     (addr),
      .dout     (dout),
      .dout_vld (dout_vld),
      .stall    (stall),
      .ar_ready (ar_ready),
      .ar_valid (ar_valid),
      .ar_addr  (ar_addr),
      .r_valid  (r_valid),
      .r_data   (r_data)
   );

   icache_checker #(
      .sets_log2 (sets_log2),
      .ways_log2 (ways_log2),
      .line_log2 (line_log2)
   ) checker_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .re          (re),
      .addr        (addr),
      .test_name   (cur_name),
      .test_refill (cur_refill),
      .stall       (stall),
      .dout        (dout),
      .dout_vld    (dout_vld),
      .ar_valid    (ar_valid),
      .ar_ready    (ar_ready),
      .ar_addr     (ar_addr),
      .r_valid     (r_valid),
      .data_errs   (data_errs),
      .refill_errs (refill_errs),
      .proto_errs  (proto_errs),
      .outstanding (outstanding)
   );

   // Memory contents as a scramble of the word address
   function automatic logic [word_w-1:0] mem_word(input logic [addr_w-1:0] byte_addr);
      logic [31:0] a;
      a = 32'(byte_addr >> word_bytes_log2);
      return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]};
   endfunction

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_bits(input int n, output int val);
      val = 0;
      for (int i = 0; i < n; i++)
      begin
         val = (val << 1) | int'(lfsr[31]);
         lfsr = lfsr_step(lfsr);
      end
   endtask

   task automatic add_row(input logic [127:0] name, input logic [addr_w-1:0] a,
                          input logic refill);
      row_t r;
      r.name = name;
      r.addr = a;
      r.refill = refill;
      rows.push_back(r);
   endtask

   // Set 0 holds lines a 0000, b 0080, c 0100, d 0180, e 0200
   task automatic build_table();
      add_row("boot_first", 16'h0000, 1'b1);
      add_row("hit_word1", 16'h0004, 1'b0);
      add_row("hit_word2", 16'h0008, 1'b0);
      add_row("hit_word3", 16'h000c, 1'b0);
      add_row("hit_word0", 16'h0000, 1'b0);
      add_row("miss_set1", 16'h0014, 1'b1);
      add_row("hit_set1_w0", 16'h0010, 1'b0);
      add_row("hit_set1_w3", 16'h001c, 1'b0);
      add_row("fill_b", 16'h0080, 1'b1);
      add_row("fill_c", 16'h0100, 1'b1);
      add_row("fill_d", 16'h0184, 1'b1);
      add_row("touch_a", 16'h0008, 1'b0);
      add_row("evict_b", 16'h0200, 1'b1);
      add_row("keep_a", 16'h000c, 1'b0);
      add_row("touch_c", 16'h0104, 1'b0);
      add_row("refill_b", 16'h0088, 1'b1);
      add_row("keep_e", 16'h0204, 1'b0);
      add_row("refill_d", 16'h0180, 1'b1);
      add_row("refill_a", 16'h0000, 1'b1);
      add_row("b2b_set1", 16'h0018, 1'b0);
      add_row("b2b_set0", 16'h0208, 1'b0);
      add_row("refill_c", 16'h0100, 1'b1);
      add_row("top_line", 16'hfff0, 1'b1);
      add_row("top_hit", 16'hfffc, 1'b0);
      add_row("keep_d", 16'h018c, 1'b0);
   endtask

   // Bus slave with random ar_ready delay and gaps between beats
   always
   begin : bus_slave
      int delay;
      int gap;
      logic [addr_w-1:0] line_addr;
      @(negedge clk);
      if (rst_n && ar_valid)
      begin
         draw_bits(2, delay);
         repeat (delay) @(negedge clk);
         line_addr = ar_addr;
         ar_ready = 1'b1;
         @(negedge clk);
         ar_ready = 1'b0;
         for (int b = 0; b < words; b++)
         begin
            draw_bits(2, gap);
            repeat (gap) @(negedge clk);
            r_valid = 1'b1;
            r_data = mem_word(line_addr + addr_w'(b * 4));
            @(negedge clk);
            r_valid = 1'b0;
         end
      end
   end

   initial
   begin
      lfsr = 32'h670f;
      rst_n = 1'b0;
      re = 1'b0;
      addr = '0;
      ar_ready = 1'b0;
      r_valid = 1'b0;
      r_data = '0;
      cur_name = '0;
      cur_refill = 1'b0;
      build_table();
      repeat (5) @(negedge clk);
      rst_n = 1'b1;
      for (int i = 0; i < rows.size(); i++)
      begin
         @(negedge clk);
         re = 1'b1;
         addr = rows[i].addr;
         cur_name = rows[i].name;
         cur_refill = rows[i].refill;
         // Held steady until the cache takes it
         while (stall)
            @(negedge clk);
      end
      @(negedge clk);
      re = 1'b0;
      while (outstanding != 0)
         @(negedge clk);
      repeat (2) @(negedge clk);
      $display("Checks done on %0d requests: %0d data, %0d refill, %0d protocol errors",
               rows.size(), data_errs, refill_errs, proto_errs);
      if (data_errs + refill_errs + proto_errs == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

   initial
   begin : watchdog
      longint limit_ns;
      @(posedge rst_n);
      limit_ns = longint'(rows.size() * (refill_bound + 10) + boot_cycles) * clk_period;
      #(limit_ns);
      $display("Watchdog expired after %0d ns with %0d requests still waiting for data",
               limit_ns, outstanding);
      $display("Test FAILED");
      $finish;
   end

endmodule

// ==== files.f ====
design/icache_pkg.sv
design/icache_tag_store.sv
design/icache_lookup.sv
design/icache_data_store.sv
design/icache_refill_ctrl.sv
design/icache_top.sv
tb/icache_checker.sv
tb/icache_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the instruction cache testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module icache_tb -f files.f -o icache_sim &&
./obj_dir/icache_sim | tee /dev/stderr | grep -x "Test OK" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
